// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_udma_rx \
    -o sim_udma_rx > build.log 2>&1 \
    && ./obj_dir/sim_udma_rx > sim.log 2>&1
grep -q "Test completed successfully" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }

// ==== tb/tb_clkgen.sv ====
// testbench clock generator and reset sequencer
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int HALF_PERIOD_NS = 2,
    parameter int RESET_CYCLES   = 3
) (
    output logic clk_o,
    output logic rstn_o
);

    initial
    begin
        clk_o  = 1'b0;
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rstn_o = 1'b1;   // released off the edge
    end

    always #(HALF_PERIOD_NS) clk_o = ~clk_o;

endmodule

// ==== tb/tb_udma_rx.sv ====
// testbench top: transfer table, channel drivers, random L2 responder and beat checks
`timescale 1ns/1ps

module tb_udma_rx;

    localparam int NCH     = 4;
    localparam int N_ROWS  = 11;
    localparam int TIMEOUT = 400;   // cycles per wait loop

    typedef struct packed {
        logic [1:0]  ch;
        logic [15:0] addr;
        logic [15:0] size;
        logic [1:0]  ds;
        logic [1:0]  dest;
        logic [31:0] seed;
        logic        pair;   // runs together with the next row
    } xfer_t;

    logic clk;
    logic rstn;
    udma_cfg_pkg::ch_addr_t     [NCH-1:0] cfg_startaddr;
    udma_cfg_pkg::ch_size_t     [NCH-1:0] cfg_size;
    udma_cfg_pkg::ch_dest_t     [NCH-1:0] cfg_dest;
    logic                       [NCH-1:0] cfg_en;
    logic                       [NCH-1:0] ch_valid;
    logic             [NCH-1:0][31:0]     ch_data;
    udma_cfg_pkg::ch_datasize_t [NCH-1:0] ch_datasize;
    logic [NCH-1:0] ch_ready;
    logic [NCH-1:0] ch_pending;
    logic [NCH-1:0] ch_done;
    logic           l2_req;
    logic           l2_gnt;
    logic [31:0]    l2_addr;
    logic [3:0]     l2_be;
    logic [31:0]    l2_wdata;

    xfer_t       rows [N_ROWS];
    logic [67:0] exp_q [NCH][$];   // {addr, be, data} per beat
    logic [31:0] lo_addr [NCH];
    logic [31:0] hi_addr [NCH];
    logic [NCH-1:0] armed;
    int gnt_seed = 32'he11b_a801;
    int r;
    int t;

    tb_clkgen u_clkgen (.clk_o(clk), .rstn_o(rstn));

    udma_rx_channels #(.N_CHANNELS(NCH), .FIFO_DEPTH(4)) uut (
        .clk_i(clk), .rstn_i(rstn),
        .cfg_startaddr_i(cfg_startaddr), .cfg_size_i(cfg_size), .cfg_dest_i(cfg_dest),
        .cfg_en_i(cfg_en), .ch_valid_i(ch_valid), .ch_data_i(ch_data),
        .ch_datasize_i(ch_datasize), .ch_ready_o(ch_ready), .ch_pending_o(ch_pending),
        .ch_done_o(ch_done), .l2_req_o(l2_req), .l2_gnt_i(l2_gnt), .l2_addr_o(l2_addr),
        .l2_be_o(l2_be), .l2_wdata_o(l2_wdata)
    );

    task automatic abort_run(input string why);
        if (why != "")
            $display("%s at %0t ns", why, $time);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        abort_run("");
    endtask

    // region base from the destination selector
    function automatic logic [31:0] bus_addr(input logic [1:0] dest, input logic [15:0] a);
        case (dest)
            2'd1:    return {12'h1A1, 4'h0, a};
            2'd2:    return {8'h10, 8'h00, a};
            default: return {8'h1C, 8'h00, a};
        endcase
    endfunction

    function automatic logic [31:0] word_data(input logic [31:0] seed, input int k);
        return seed ^ (k * 32'h9e37_79b9);
    endfunction

    // one or two beats per word from the split rule
    task automatic expect_word(input int ch, input logic [15:0] a, input logic [1:0] ds,
                               input logic [1:0] dest, input logic [31:0] d);
        int n;
        int o;
        logic [7:0]  bew;
        logic [63:0] dw;
        logic [15:0] wa;
        n   = (ds == 2'd0) ? 1 : (ds == 2'd1) ? 2 : 4;
        o   = int'(a[1:0]);
        bew = ((8'h1 << n) - 8'h1) << o;
        dw  = ({32'h0, d} & ((64'h1 << (8 * n)) - 64'h1)) << (8 * o);
        wa  = {a[15:2], 2'b00};
        exp_q[ch].push_back({bus_addr(dest, wa), bew[3:0], dw[31:0]});
        if (o + n > 4)
            exp_q[ch].push_back({bus_addr(dest, wa + 16'd4), bew[7:4], dw[63:32]});
    endtask

    task automatic run_channel(input int row);
        xfer_t x;
        int ch;
        int step;
        int k;
        int wait_cnt;
        logic accepted;
        logic [15:0] last;
        x    = rows[row];
        ch   = int'(x.ch);
        step = (x.ds == 2'd0) ? 1 : (x.ds == 2'd1) ? 2 : 4;
        last = x.addr + x.size - 16'd1;
        lo_addr[ch] = bus_addr(x.dest, {x.addr[15:2], 2'b00});
        hi_addr[ch] = bus_addr(x.dest, {last[15:2], 2'b00});
        for (k = 0; k < int'(x.size) / step; k++)
            expect_word(ch, x.addr + 16'(k * step), x.ds, x.dest, word_data(x.seed, k));
        @(posedge clk);
        #1;
        cfg_startaddr[ch] = x.addr;
        cfg_size[ch]      = x.size;
        cfg_dest[ch]      = x.dest;
        cfg_en[ch]        = 1'b1;
        @(posedge clk);
        #1;
        cfg_en[ch] = 1'b0;
        armed[ch]  = 1'b1;
        for (k = 0; k < int'(x.size) / step; k++)
        begin
            ch_valid[ch]    = 1'b1;
            ch_data[ch]     = word_data(x.seed, k);
            ch_datasize[ch] = x.ds;
            accepted = 1'b0;
            wait_cnt = 0;
            while (!accepted)
            begin
                @(negedge clk);
                // still mid-block, no early done
                assert (ch_done[ch] == 1'b0) else report_mismatch("ch_done_o", 0, ch_done[ch]);
                assert (ch_pending[ch] == 1'b1)
                    else report_mismatch("ch_pending_o", 1, ch_pending[ch]);
                if (ch_ready[ch])
                    accepted = 1'b1;
                else
                begin
                    wait_cnt++;
                    if (wait_cnt > TIMEOUT)
                        abort_run("timeout waiting for channel ready");
                end
            end
            @(posedge clk);
            #1;
        end
        ch_valid[ch] = 1'b0;
        @(negedge clk);
        assert (ch_done[ch] == 1'b1) else report_mismatch("ch_done_o", 1, ch_done[ch]);
        assert (ch_pending[ch] == 1'b0) else report_mismatch("ch_pending_o", 0, ch_pending[ch]);
        armed[ch] = 1'b0;
        @(negedge clk);
        assert (ch_done[ch] == 1'b0) else report_mismatch("ch_done_o", 0, ch_done[ch]);
    endtask

    task automatic drain_wait();
        int wait_cnt;
        wait_cnt = 0;
        while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() + exp_q[3].size() != 0
               || l2_req)
        begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > TIMEOUT)
                abort_run("timeout waiting for the L2 beats to drain");
        end
    endtask

    task automatic check_beat();
        int c;
        logic [67:0] e;
        c = -1;
        for (int i = 0; i < NCH; i++)
            if (exp_q[i].size() != 0 && l2_addr >= lo_addr[i] && l2_addr <= hi_addr[i])
                c = i;
        if (c < 0)
            abort_run("L2 beat at an address no channel expects");
        else
        begin
            e = exp_q[c].pop_front();
            assert (l2_addr == e[67:36]) else report_mismatch("l2_addr_o", e[67:36], l2_addr);
            assert (l2_be == e[35:32])
                else report_mismatch("l2_be_o", 32'(e[35:32]), 32'(l2_be));
            assert (l2_wdata == e[31:0]) else report_mismatch("l2_wdata_o", e[31:0], l2_wdata);
        end
    endtask

    // L2 responder with random stalls
    always @(posedge clk)
    begin
        #1;
        l2_gnt = rstn && (($random(gnt_seed) & 3) != 0);
    end

    always @(negedge clk)
    begin
        if (rstn)
        begin
            assert ((ch_ready & ~armed) == '0) else report_mismatch("ch_ready_o", 0, 32'(ch_ready));
            if (l2_req && l2_gnt)
                check_beat();
        end
    end

    initial
    begin
        rows[0]  = '{2'd0, 16'h0100, 16'd16, 2'd2, 2'd0, 32'hA5A5_0001, 1'b0};
        rows[1]  = '{2'd1, 16'h0200, 16'd8,  2'd2, 2'd1, 32'h1234_5678, 1'b0};
        rows[2]  = '{2'd2, 16'h0300, 16'd8,  2'd2, 2'd2, 32'hCAFE_0F0F, 1'b0};
        rows[3]  = '{2'd0, 16'h0040, 16'd8,  2'd2, 2'd3, 32'h0BAD_F00D, 1'b0};
        rows[4]  = '{2'd1, 16'h0401, 16'd4,  2'd0, 2'd0, 32'h8877_6655, 1'b0};
        rows[5]  = '{2'd2, 16'h0500, 16'd8,  2'd1, 2'd1, 32'h4433_2211, 1'b0};
        rows[6]  = '{2'd0, 16'h0601, 16'd6,  2'd1, 2'd2, 32'hDEAD_BEEF, 1'b0};
        rows[7]  = '{2'd1, 16'h0703, 16'd8,  2'd2, 2'd0, 32'h0102_0304, 1'b0};
        rows[8]  = '{2'd2, 16'h0802, 16'd8,  2'd2, 2'd1, 32'hF0E1_D2C3, 1'b0};
        rows[9]  = '{2'd0, 16'h0900, 16'd32, 2'd2, 2'd0, 32'h5566_7788, 1'b1};
        rows[10] = '{2'd1, 16'h0A03, 16'd24, 2'd1, 2'd2, 32'h99AA_BBCC, 1'b0};
        cfg_startaddr = '0;
        cfg_size      = '0;
        cfg_dest      = '0;
        cfg_en        = '0;
        ch_valid      = 4'b1000;   // channel 3 asks but is never armed
        ch_data       = '0;
        ch_datasize   = '0;
        l2_gnt        = 1'b0;
        armed         = '0;
        t = 0;
        while (rstn !== 1'b1)
        begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT)
                abort_run("timeout waiting for reset release");
        end
        @(negedge clk);
        assert (l2_req == 1'b0) else report_mismatch("l2_req_o", 0, l2_req);
        assert (ch_ready == '0) else report_mismatch("ch_ready_o", 0, 32'(ch_ready));
        assert (ch_pending == '0) else report_mismatch("ch_pending_o", 0, 32'(ch_pending));
        assert (ch_done == '0) else report_mismatch("ch_done_o", 0, 32'(ch_done));
        r = 0;
        while (r < N_ROWS)
        begin
            if (rows[r].pair)
            begin
                fork
                    run_channel(r);
                    run_channel(r + 1);
                join
                r += 2;
            end
            else
            begin
                run_channel(r);
                r++;
            end
            drain_wait();
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== tb/udma_rx_asserts.sv ====
// concurrent bus and ready checks bound into the RX channels top
`timescale 1ns/1ps

module udma_rx_asserts #(
    parameter int N_CHANNELS = 4
) (
    input logic                  clk_i,
    input logic                  rstn_i,
    input logic                  l2_req_o,
    input logic                  l2_gnt_i,
    input logic [31:0]           l2_addr_o,
    input logic [3:0]            l2_be_o,
    input logic [31:0]           l2_wdata_o,
    input logic [N_CHANNELS-1:0] ch_ready_o
);

    // a stalled request keeps its address, enables and data
    a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (l2_req_o && !l2_gnt_i) |=> ($stable(l2_addr_o) && $stable(l2_be_o) && $stable(l2_wdata_o)))
        else $error("L2 request changed while waiting for grant");

    a_be_nonzero: assert property (@(posedge clk_i) disable iff (!rstn_i)
        l2_req_o |-> (l2_be_o != 4'b0000))
        else $error("L2 request without byte enables");

    a_ready_onehot: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(ch_ready_o))
        else $error("more than one channel ready");

endmodule

bind udma_rx_channels udma_rx_asserts #(
    .N_CHANNELS ( N_CHANNELS )
) u_asserts (
    .clk_i      ( clk_i      ),
    .rstn_i     ( rstn_i     ),
    .l2_req_o   ( l2_req_o   ),
    .l2_gnt_i   ( l2_gnt_i   ),
    .l2_addr_o  ( l2_addr_o  ),
    .l2_be_o    ( l2_be_o    ),
    .l2_wdata_o ( l2_wdata_o ),
    .ch_ready_o ( ch_ready_o )
);

// ==== verilog.f ====
verilog/udma_cfg_pkg.sv
verilog/udma_l2_pkg.sv
verilog/udma_rx_ch_addrgen.sv
verilog/udma_rx_arbiter.sv
verilog/udma_rx_fifo.sv
verilog/udma_l2_write_align.sv
verilog/udma_rx_channels.sv
tb/tb_clkgen.sv
tb/udma_rx_asserts.sv
tb/tb_udma_rx.sv

// ==== verilog/udma_cfg_pkg.sv ====
// channel-side widths, channel address/size/destination types and datasize codes
package udma_cfg_pkg;

    ////////////////////
    // widths
    localparam int L2_AWIDTH_NOAL = 16;  // region-relative byte address
    localparam int TRANS_SIZE     = 16;  // byte count field
    localparam int DEST_SIZE      = 2;

    ////////////////////
    // channel types
    typedef logic [L2_AWIDTH_NOAL-1:0] ch_addr_t;
    typedef logic [TRANS_SIZE-1:0]     ch_size_t;
    typedef logic [DEST_SIZE-1:0]      ch_dest_t;
    typedef logic [1:0]                ch_datasize_t;

    // transfer size codes, code 3 is unused
    localparam ch_datasize_t DS_BYTE = 2'd0;
    localparam ch_datasize_t DS_HALF = 2'd1;
    localparam ch_datasize_t DS_WORD = 2'd2;

endpackage

// ==== verilog/udma_l2_pkg.sv ====
// L2 bus widths and types, destination base constants, FIFO entry type
package udma_l2_pkg;

    localparam int L2_DATA_WIDTH = 32;
    localparam int L2_BE_WIDTH   = L2_DATA_WIDTH / 8;
    localparam int ALIGN_BITS    = 2;    // byte offset inside a bus word

    typedef logic [31:0]              l2_addr_t;
    typedef logic [L2_DATA_WIDTH-1:0] l2_data_t;
    typedef logic [L2_BE_WIDTH-1:0]   l2_be_t;

    ////////////////////
    // destination bases, selector 3 maps like selector 0
    localparam logic [7:0]  DEST_BASE_0 = 8'h1C;   // bits 31:24
    localparam logic [11:0] DEST_BASE_1 = 12'h1A1; // bits 31:20
    localparam logic [7:0]  DEST_BASE_2 = 8'h10;   // bits 31:24

    // one sampled channel word on its way to L2
    typedef struct packed {
        udma_cfg_pkg::ch_dest_t     dest;
        udma_cfg_pkg::ch_datasize_t datasize;
        udma_cfg_pkg::ch_addr_t     addr;
        l2_data_t                   data;
    } l2_entry_t;

endpackage

// ==== verilog/udma_l2_write_align.sv ====
// L2 write aligner: byte enables, lane shift, destination base and misaligned split FSM
`timescale 1ns/1ps

module udma_l2_write_align (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  udma_l2_pkg::l2_entry_t entry_i,
    input  logic                   entry_valid_i,
    output logic                   pop_o,
    output logic                   l2_req_o,
    input  logic                   l2_gnt_i,
    output udma_l2_pkg::l2_addr_t  l2_addr_o,
    output udma_l2_pkg::l2_be_t    l2_be_o,
    output udma_l2_pkg::l2_data_t  l2_wdata_o
);

    localparam int AB = udma_l2_pkg::ALIGN_BITS;
    localparam int BW = udma_l2_pkg::L2_BE_WIDTH;
    localparam int DW = udma_l2_pkg::L2_DATA_WIDTH;
    localparam int WA = udma_cfg_pkg::L2_AWIDTH_NOAL - AB;

    typedef enum logic {IDLE, SECOND_BEAT} state_t;

    state_t                r_state;
    state_t                s_state_next;
    logic [AB-1:0]         s_offset;
    logic                  s_misaligned;
    logic                  s_second;
    udma_l2_pkg::l2_be_t   s_size_mask;
    udma_l2_pkg::l2_data_t s_data_masked;
    logic [2*BW-1:0]       s_be_wide;    // enables over two consecutive words
    logic [2*DW-1:0]       s_data_wide;
    logic [WA-1:0]         s_word_addr;

    assign s_offset = entry_i.addr[AB-1:0];
    assign s_second = (r_state == SECOND_BEAT);

    always_comb
    begin
        case (entry_i.datasize)
            udma_cfg_pkg::DS_BYTE:
            begin
                s_size_mask   = 4'b0001;
                s_data_masked = {24'h0, entry_i.data[7:0]};
            end
            udma_cfg_pkg::DS_HALF:
            begin
                s_size_mask   = 4'b0011;
                s_data_masked = {16'h0, entry_i.data[15:0]};
            end
            default:
            begin
                s_size_mask   = 4'b1111;
                s_data_masked = entry_i.data;
            end
        endcase
    end

    // halfword at offset 3 or word off the boundary spills into the next word
    assign s_misaligned = ((entry_i.datasize == udma_cfg_pkg::DS_HALF) && (s_offset == 2'd3)) ||
                          ((entry_i.datasize != udma_cfg_pkg::DS_BYTE) &&
                           (entry_i.datasize != udma_cfg_pkg::DS_HALF) && (s_offset != 2'd0));

    assign s_be_wide   = {{BW{1'b0}}, s_size_mask} << s_offset;
    assign s_data_wide = {{DW{1'b0}}, s_data_masked} << {s_offset, 3'b000};

    ////////////////////
    // split FSM
    always_comb
    begin
        s_state_next = r_state;
        pop_o        = 1'b0;
        case (r_state)
            IDLE:
            begin
                if (entry_valid_i && l2_gnt_i)
                begin
                    if (s_misaligned)
                        s_state_next = SECOND_BEAT;
                    else
                        pop_o = 1'b1;
                end
            end
            default:
            begin
                if (entry_valid_i && l2_gnt_i)
                begin
                    pop_o        = 1'b1; // entry leaves on the last beat
                    s_state_next = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_state <= IDLE;
        else
            r_state <= s_state_next;
    end

    ////////////////////
    // bus outputs
    assign s_word_addr = entry_i.addr[udma_cfg_pkg::L2_AWIDTH_NOAL-1:AB] + WA'(s_second);
    assign l2_req_o    = entry_valid_i;
    assign l2_be_o     = s_second ? s_be_wide[2*BW-1:BW] : s_be_wide[BW-1:0];
    assign l2_wdata_o  = s_second ? s_data_wide[2*DW-1:DW] : s_data_wide[DW-1:0];

    always_comb
    begin
        l2_addr_o = {{(32-udma_cfg_pkg::L2_AWIDTH_NOAL){1'b0}}, s_word_addr, {AB{1'b0}}};
        case (entry_i.dest)
            2'd1:    l2_addr_o[31:20] = udma_l2_pkg::DEST_BASE_1;
            2'd2:    l2_addr_o[31:24] = udma_l2_pkg::DEST_BASE_2;
            default: l2_addr_o[31:24] = udma_l2_pkg::DEST_BASE_0;
        endcase
    end

endmodule

// ==== verilog/udma_rx_arbiter.sv ====
// round-robin arbiter, pointer advances only on grant acknowledge
`timescale 1ns/1ps

module udma_rx_arbiter #(
    parameter int N_CHANNELS = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic [N_CHANNELS-1:0] req_i,
    input  logic                  ack_i,
    output logic [N_CHANNELS-1:0] grant_o,
    output logic                  any_grant_o
);

    localparam int PTR_W = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

    logic [PTR_W-1:0] r_ptr;       // highest priority requester
    logic [PTR_W-1:0] s_grant_idx;
    logic             s_found;

    // first request at or after the pointer wins
    always_comb
    begin : search
        int idx;
        grant_o     = '0;
        s_grant_idx = '0;
        s_found     = 1'b0;
        for (int k = 0; k < N_CHANNELS; k++)
        begin
            idx = (int'(r_ptr) + k) % N_CHANNELS;
            if (!s_found && req_i[idx])
            begin
                grant_o[idx] = 1'b1;
                s_grant_idx  = PTR_W'(idx);
                s_found      = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_ptr <= '0;
        else if (ack_i && s_found)
            r_ptr <= (s_grant_idx == PTR_W'(N_CHANNELS-1)) ? '0 : s_grant_idx + 1'b1;
    end

    assign any_grant_o = s_found;

endmodule

// ==== verilog/udma_rx_ch_addrgen.sv ====
// per-channel address generator with byte counter, pending flag and done pulse
`timescale 1ns/1ps

module udma_rx_ch_addrgen (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  udma_cfg_pkg::ch_addr_t     cfg_startaddr_i,
    input  udma_cfg_pkg::ch_size_t     cfg_size_i,
    input  logic                       cfg_en_i,
    input  udma_cfg_pkg::ch_datasize_t datasize_i,
    input  logic                       accept_i,
    output udma_cfg_pkg::ch_addr_t     curr_addr_o,
    output logic                       pending_o,
    output logic                       done_o
);

    udma_cfg_pkg::ch_addr_t r_addr;
    udma_cfg_pkg::ch_size_t r_count;   // bytes still to come
    udma_cfg_pkg::ch_size_t s_step;
    logic                   r_pending;
    logic                   r_done;

    // bytes per accepted word
    always_comb
    begin
        case (datasize_i)
            udma_cfg_pkg::DS_BYTE: s_step = udma_cfg_pkg::ch_size_t'(1);
            udma_cfg_pkg::DS_HALF: s_step = udma_cfg_pkg::ch_size_t'(2);
            default:               s_step = udma_cfg_pkg::ch_size_t'(4);
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_addr    <= '0;
            r_count   <= '0;
            r_pending <= 1'b0;
            r_done    <= 1'b0;
        end
        else
        begin
            r_done <= 1'b0;
            if (cfg_en_i)
            begin
                r_addr    <= cfg_startaddr_i;
                r_count   <= cfg_size_i;
                r_pending <= (cfg_size_i != '0);
            end
            else if (accept_i && r_pending)
            begin
                r_addr  <= r_addr + udma_cfg_pkg::ch_addr_t'(s_step);
                r_count <= r_count - s_step;
                if (r_count <= s_step) // last word of the block
                begin
                    r_pending <= 1'b0;
                    r_done    <= 1'b1;
                end
            end
        end
    end

    assign curr_addr_o = r_addr;
    assign pending_o   = r_pending;
    assign done_o      = r_done;

endmodule

// ==== verilog/udma_rx_channels.sv ====
// RX channels top: channel addrgens, arbiter, input mux, sample register, FIFO and L2 aligner
`timescale 1ns/1ps

module udma_rx_channels #(
    parameter int N_CHANNELS = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic                                        clk_i,
    input  logic                                        rstn_i,
    input  udma_cfg_pkg::ch_addr_t     [N_CHANNELS-1:0] cfg_startaddr_i,
    input  udma_cfg_pkg::ch_size_t     [N_CHANNELS-1:0] cfg_size_i,
    input  udma_cfg_pkg::ch_dest_t     [N_CHANNELS-1:0] cfg_dest_i,
    input  logic                       [N_CHANNELS-1:0] cfg_en_i,
    input  logic                       [N_CHANNELS-1:0] ch_valid_i,
    input  logic           [N_CHANNELS-1:0][31:0]       ch_data_i,
    input  udma_cfg_pkg::ch_datasize_t [N_CHANNELS-1:0] ch_datasize_i,
    output logic                       [N_CHANNELS-1:0] ch_ready_o,
    output logic                       [N_CHANNELS-1:0] ch_pending_o,
    output logic                       [N_CHANNELS-1:0] ch_done_o,
    output logic                                        l2_req_o,
    input  logic                                        l2_gnt_i,
    output udma_l2_pkg::l2_addr_t                       l2_addr_o,
    output udma_l2_pkg::l2_be_t                         l2_be_o,
    output udma_l2_pkg::l2_data_t                       l2_wdata_o
);

    udma_cfg_pkg::ch_dest_t [N_CHANNELS-1:0] r_dest;
    udma_cfg_pkg::ch_addr_t [N_CHANNELS-1:0] s_curr_addr;
    logic                   [N_CHANNELS-1:0] s_req;
    logic                   [N_CHANNELS-1:0] s_grant;
    logic                   [N_CHANNELS-1:0] s_accept;
    logic                                    s_any_grant;
    logic                                    s_fifo_ready;
    logic                                    s_sample;
    logic                                    s_push;
    logic                                    s_pop;
    logic                                    s_head_valid;
    udma_l2_pkg::l2_entry_t                  s_mux_entry;
    udma_l2_pkg::l2_entry_t                  s_head;
    udma_l2_pkg::l2_entry_t                  r_entry;
    logic                                    r_anygrant;

    assign s_req      = ch_valid_i & ch_pending_o;
    assign s_sample   = s_any_grant & s_fifo_ready;
    assign ch_ready_o = s_grant & {N_CHANNELS{s_fifo_ready}};
    assign s_accept   = ch_valid_i & ch_ready_o;
    assign s_push     = r_anygrant & s_fifo_ready;

    for (genvar i = 0; i < N_CHANNELS; i++)
    begin : g_ch
        udma_rx_ch_addrgen u_addrgen (
            .clk_i           ( clk_i              ),
            .rstn_i          ( rstn_i             ),
            .cfg_startaddr_i ( cfg_startaddr_i[i] ),
            .cfg_size_i      ( cfg_size_i[i]      ),
            .cfg_en_i        ( cfg_en_i[i]        ),
            .datasize_i      ( ch_datasize_i[i]   ),
            .accept_i        ( s_accept[i]        ),
            .curr_addr_o     ( s_curr_addr[i]     ),
            .pending_o       ( ch_pending_o[i]    ),
            .done_o          ( ch_done_o[i]       )
        );
    end

    // destination latched when the channel is armed
    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_dest <= '0;
        else
            for (int i = 0; i < N_CHANNELS; i++)
                if (cfg_en_i[i])
                    r_dest[i] <= cfg_dest_i[i];
    end

    udma_rx_arbiter #(
        .N_CHANNELS ( N_CHANNELS )
    ) u_arbiter (
        .clk_i       ( clk_i       ),
        .rstn_i      ( rstn_i      ),
        .req_i       ( s_req       ),
        .ack_i       ( s_sample    ),
        .grant_o     ( s_grant     ),
        .any_grant_o ( s_any_grant )
    );

    ////////////////////
    // input mux and sample register
    always_comb
    begin
        s_mux_entry = '0;
        for (int i = 0; i < N_CHANNELS; i++)
        begin
            if (s_grant[i])
            begin
                s_mux_entry.data     = ch_data_i[i];
                s_mux_entry.addr     = s_curr_addr[i];
                s_mux_entry.datasize = ch_datasize_i[i];
                s_mux_entry.dest     = r_dest[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            r_anygrant <= 1'b0;
        else if (s_sample)
            r_anygrant <= s_any_grant;
        else if (s_push)
            r_anygrant <= 1'b0;   // drained, nothing new
    end

    always_ff @(posedge clk_i)
    begin
        if (s_sample)
            r_entry <= s_mux_entry;
    end

    udma_rx_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_fifo (
        .clk_i   ( clk_i        ),
        .rstn_i  ( rstn_i       ),
        .push_i  ( s_push       ),
        .data_i  ( r_entry      ),
        .ready_o ( s_fifo_ready ),
        .pop_i   ( s_pop        ),
        .valid_o ( s_head_valid ),
        .data_o  ( s_head       )
    );

    udma_l2_write_align u_align (
        .clk_i         ( clk_i        ),
        .rstn_i        ( rstn_i       ),
        .entry_i       ( s_head       ),
        .entry_valid_i ( s_head_valid ),
        .pop_o         ( s_pop        ),
        .l2_req_o      ( l2_req_o     ),
        .l2_gnt_i      ( l2_gnt_i     ),
        .l2_addr_o     ( l2_addr_o    ),
        .l2_be_o       ( l2_be_o      ),
        .l2_wdata_o    ( l2_wdata_o   )
    );

endmodule

// ==== verilog/udma_rx_fifo.sv ====
// circular FIFO of L2 entries with occupancy counter
`timescale 1ns/1ps

module udma_rx_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  push_i,
    input  udma_l2_pkg::l2_entry_t data_i,
    output logic                  ready_o,
    input  logic                  pop_i,
    output logic                  valid_o,
    output udma_l2_pkg::l2_entry_t data_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    udma_l2_pkg::l2_entry_t r_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]       r_wr_ptr;
    logic [PTR_W-1:0]       r_rd_ptr;
    logic [CNT_W-1:0]       r_count;
    logic                   s_wr;
    logic                   s_rd;

    assign ready_o = (r_count != CNT_W'(FIFO_DEPTH));
    assign valid_o = (r_count != '0);
    assign s_wr    = push_i & ready_o;
    assign s_rd    = pop_i & valid_o;
    assign data_o  = r_mem[r_rd_ptr];

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end
        else
        begin
            if (s_wr)
                r_wr_ptr <= (r_wr_ptr == PTR_W'(FIFO_DEPTH-1)) ? '0 : r_wr_ptr + 1'b1;
            if (s_rd)
                r_rd_ptr <= (r_rd_ptr == PTR_W'(FIFO_DEPTH-1)) ? '0 : r_rd_ptr + 1'b1;
            if (s_wr != s_rd)
                r_count <= s_wr ? r_count + 1'b1 : r_count - 1'b1;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (s_wr)
            r_mem[r_wr_ptr] <= data_i;
    end

endmodule
